// File: design/arb_pkg.sv
package arb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes of the arbitration tree
  ////////////////////////////////////////////////////////////////////////////

  // number of requesters sharing the downstream port
  localparam int unsigned NUM_IN = 8;

  // payload carried alongside every request
  localparam int unsigned DATA_WIDTH = 16;

  // width of an input index, also the width of the round-robin priority
  localparam int unsigned IDX_WIDTH = $clog2(NUM_IN);

  // every piece of arbitration state exists in this many copies
  localparam int unsigned NUM_LANES = 3;

  // a full binary tree over the padded inputs has one node less than leaves
  localparam int unsigned NUM_NODES = 2 ** IDX_WIDTH - 1;

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  // one bit per requester, used for requests and grants alike
  typedef logic [NUM_IN-1:0] req_vec_t;
  // index of an input, or the input that currently holds top priority
  typedef logic [IDX_WIDTH-1:0] idx_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  // select bit of every tree node, root at bit 0 and children of n at 2n+1, 2n+2
  typedef logic [NUM_NODES-1:0] node_sel_t;

endpackage

// File: design/tmr_vote.sv
module tmr_vote #(
  parameter int unsigned width = 1
) (
  input  logic [width-1:0] a_i,
  input  logic [width-1:0] b_i,
  input  logic [width-1:0] c_i,
  output logic [width-1:0] maj_o,
  output logic             fault_o
);

  // per-bit disagreement between the three copies
  logic [width-1:0] mismatch;

  // two of three copies win on every bit position
  assign maj_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // a bit is suspicious as soon as one copy differs from the others, the
  // third comparison b against c adds nothing since a is in both pairs
  assign mismatch = (a_i ^ b_i) | (a_i ^ c_i);

  assign fault_o = |mismatch;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // a defined majority has to come with a defined fault flag
  // an undefined copy would otherwise hide behind the two copies that agree
  always_comb begin
    if (!$isunknown(maj_o)) begin
      assert final (!$isunknown(fault_o))
        else $error("voter fault flag is unknown with a known majority");
    end
  end

endmodule

// File: design/trailing_zero_count.sv
module trailing_zero_count #(
  parameter int unsigned width = 8
) (
  input  logic [width-1:0]         in_i,
  output logic [$clog2(width)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int unsigned cnt_width = $clog2(width);

  typedef logic [cnt_width-1:0] cnt_t;

  // the count equals the position of the lowest set bit
  // scanning from the top down lets the lowest hit overwrite all others
  always_comb begin
    cnt_o = '0;
    for (int i = width - 1; i >= 0; i--) begin
      if (in_i[i]) begin
        cnt_o = cnt_t'(i);
      end
    end
  end

  // with no bit set the count stays at zero, so callers need this flag
  // to tell an empty mask from a set bit 0
  assign empty_o = ~|in_i;

endmodule

// File: design/rr_arb_lane.sv
module rr_arb_lane #(
  parameter bit lock_in = 1'b1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  arb_pkg::req_vec_t       req_i,
  input  logic                    gnt_i,
  input  logic [1:0]              nbr_lock_i,
  input  arb_pkg::req_vec_t [1:0] nbr_req_i,
  input  arb_pkg::idx_t [1:0]     nbr_prio_i,
  output arb_pkg::req_vec_t       gnt_o,
  output logic                    req_o,
  output arb_pkg::idx_t           idx_o,
  output arb_pkg::node_sel_t      node_sel_o,
  output logic                    lock_o,
  output arb_pkg::req_vec_t       held_req_o,
  output arb_pkg::idx_t           prio_o,
  output logic                    fault_o
);

  // the tree is built over a power of two, missing inputs never request
  localparam int unsigned num_leaves = arb_pkg::NUM_NODES + 1;

  // raw registers of this lane, shared with the neighbour lanes
  logic              lock_q;
  arb_pkg::req_vec_t held_q;
  arb_pkg::idx_t     prio_q;
  // state in use, after the vote against the two neighbour copies
  logic              lock_v;
  arb_pkg::req_vec_t held_v;
  arb_pkg::idx_t     prio_v;
  logic [2:0]        vote_fault;
  // next state
  logic              lock_d;
  arb_pkg::req_vec_t req_eff;
  arb_pkg::idx_t     prio_d;
  arb_pkg::req_vec_t upper_mask;
  arb_pkg::req_vec_t lower_mask;
  arb_pkg::idx_t     upper_idx;
  arb_pkg::idx_t     lower_idx;
  arb_pkg::idx_t     next_prio;
  logic              upper_empty;
  logic              lower_empty;
  // arbitration tree
  logic [num_leaves-1:0]                  req_pad;
  logic [num_leaves-1:0]                  gnt_pad;
  logic [arb_pkg::NUM_NODES-1:0]          req_nodes;
  logic [arb_pkg::NUM_NODES-1:0]          gnt_nodes;
  arb_pkg::node_sel_t                     sel;
  arb_pkg::idx_t [arb_pkg::NUM_NODES-1:0] idx_nodes;

  ////////////////////////////////////////////////////////////////////////////
  // state registers, voted after the register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
      held_q <= '0;
      prio_q <= '0;
    end else if (flush_i) begin
      lock_q <= 1'b0;
      held_q <= '0;
      prio_q <= '0;
    end else begin
      lock_q <= lock_d;
      held_q <= req_eff;
      prio_q <= prio_d;
    end
  end

  // a single upset copy is outvoted here and overwritten at the next edge
  tmr_vote #(.width(1)) i_lock_vote (
    .a_i     (lock_q),
    .b_i     (nbr_lock_i[0]),
    .c_i     (nbr_lock_i[1]),
    .maj_o   (lock_v),
    .fault_o (vote_fault[0])
  );

  tmr_vote #(.width(arb_pkg::NUM_IN)) i_held_vote (
    .a_i     (held_q),
    .b_i     (nbr_req_i[0]),
    .c_i     (nbr_req_i[1]),
    .maj_o   (held_v),
    .fault_o (vote_fault[1])
  );

  tmr_vote #(.width(arb_pkg::IDX_WIDTH)) i_prio_vote (
    .a_i     (prio_q),
    .b_i     (nbr_prio_i[0]),
    .c_i     (nbr_prio_i[1]),
    .maj_o   (prio_v),
    .fault_o (vote_fault[2])
  );

  assign lock_o     = lock_q;
  assign held_req_o = held_q;
  assign prio_o     = prio_q;
  assign fault_o    = |vote_fault;

  // while locked the stalled request set is frozen, new requests wait
  assign req_eff = lock_v ? held_v : req_i;
  // a stall locks the decision, the first cycle without a stall releases it
  assign lock_d  = lock_in & req_o & ~gnt_i;

  ////////////////////////////////////////////////////////////////////////////
  // fair next priority
  ////////////////////////////////////////////////////////////////////////////

  // requests strictly above the current priority are served first,
  // the lower mask holds the wrapped candidates
  always_comb begin
    for (int i = 0; i < arb_pkg::NUM_IN; i++) begin
      upper_mask[i] = (i > int'(prio_v)) ? req_eff[i] : 1'b0;
      lower_mask[i] = (i <= int'(prio_v)) ? req_eff[i] : 1'b0;
    end
  end

  trailing_zero_count #(.width(arb_pkg::NUM_IN)) i_tzc_upper (
    .in_i    (upper_mask),
    .cnt_o   (upper_idx),
    .empty_o (upper_empty)
  );

  trailing_zero_count #(.width(arb_pkg::NUM_IN)) i_tzc_lower (
    .in_i    (lower_mask),
    .cnt_o   (lower_idx),
    .empty_o (lower_empty)
  );

  always_comb begin
    if (!upper_empty) begin
      next_prio = upper_idx;
    end else if (!lower_empty) begin
      next_prio = lower_idx;
    end else begin
      next_prio = prio_v;
    end
  end

  // the priority only moves on a transfer
  assign prio_d = (req_o & gnt_i) ? next_prio : prio_v;

  ////////////////////////////////////////////////////////////////////////////
  // request, index and grant tree
  ////////////////////////////////////////////////////////////////////////////

  // bottom-up pass, the root level uses the msb of the priority
  always_comb begin
    int            n;
    logic          lo;
    logic          hi;
    arb_pkg::idx_t lo_idx;
    arb_pkg::idx_t hi_idx;
    req_pad = '0;
    req_pad[arb_pkg::NUM_IN-1:0] = req_eff;
    req_nodes = '0;
    sel       = '0;
    idx_nodes = '0;
    for (int lvl = arb_pkg::IDX_WIDTH - 1; lvl >= 0; lvl--) begin
      for (int l = 0; l < 2 ** lvl; l++) begin
        n = 2 ** lvl - 1 + l;
        if (lvl == arb_pkg::IDX_WIDTH - 1) begin
          lo     = req_pad[2*l];
          hi     = req_pad[2*l+1];
          lo_idx = '0;
          hi_idx = '0;
        end else begin
          lo     = req_nodes[2*n+1];
          hi     = req_nodes[2*n+2];
          lo_idx = idx_nodes[2*n+1];
          hi_idx = idx_nodes[2*n+2];
        end
        // upper half wins if the lower half is idle or the priority bit says so
        sel[n]       = ~lo | (hi & prio_v[arb_pkg::IDX_WIDTH-1-lvl]);
        req_nodes[n] = lo | hi;
        idx_nodes[n] = (sel[n] ? hi_idx : lo_idx) |
                       (arb_pkg::idx_t'(sel[n]) << (arb_pkg::IDX_WIDTH - 1 - lvl));
      end
    end
  end

  // top-down pass, the downstream grant follows the selects to one leaf
  always_comb begin
    int n;
    gnt_nodes    = '0;
    gnt_pad      = '0;
    gnt_nodes[0] = gnt_i;
    for (int lvl = 0; lvl < arb_pkg::IDX_WIDTH; lvl++) begin
      for (int l = 0; l < 2 ** lvl; l++) begin
        n = 2 ** lvl - 1 + l;
        if (lvl == arb_pkg::IDX_WIDTH - 1) begin
          gnt_pad[2*l]   = gnt_nodes[n] & ~sel[n] & req_pad[2*l];
          gnt_pad[2*l+1] = gnt_nodes[n] & sel[n] & req_pad[2*l+1];
        end else begin
          gnt_nodes[2*n+1] = gnt_nodes[n] & ~sel[n];
          gnt_nodes[2*n+2] = gnt_nodes[n] & sel[n];
        end
      end
    end
  end

  assign gnt_o      = gnt_pad[arb_pkg::NUM_IN-1:0];
  assign req_o      = req_nodes[0];
  assign idx_o      = idx_nodes[0];
  assign node_sel_o = sel;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    $onehot0(gnt_o))
    else $error("lane grant is not one-hot");

  a_gnt_needs_gnt_i : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    |gnt_o |-> gnt_i)
    else $error("lane grant without downstream grant");

  // the locked decision has to survive the neighbour vote into the next cycle
  a_lock_keeps_idx : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    lock_in && req_o && !gnt_i |=> idx_o == $past(idx_o))
    else $error("stalled decision changed under lock-in");

endmodule

// File: design/data_tree_mux.sv
module data_tree_mux (
  input  arb_pkg::node_sel_t [2:0]                node_sel_i,
  input  arb_pkg::data_t [arb_pkg::NUM_IN-1:0]    data_i,
  output arb_pkg::data_t                          data_o,
  output logic                                    fault_o
);

  localparam int unsigned num_leaves = arb_pkg::NUM_NODES + 1;

  // selects agreed on by the lanes
  arb_pkg::node_sel_t                      sel_v;
  arb_pkg::data_t [num_leaves-1:0]         data_pad;
  arb_pkg::data_t [arb_pkg::NUM_NODES-1:0] data_nodes;

  // every data bit is steered by voted selects, so one bad lane cannot
  // corrupt the payload
  tmr_vote #(.width(arb_pkg::NUM_NODES)) i_sel_vote (
    .a_i     (node_sel_i[0]),
    .b_i     (node_sel_i[1]),
    .c_i     (node_sel_i[2]),
    .maj_o   (sel_v),
    .fault_o (fault_o)
  );

  // leaves take input pairs, inner nodes take the results of their children
  always_comb begin
    int n;
    data_pad   = '0;
    data_nodes = '0;
    for (int i = 0; i < arb_pkg::NUM_IN; i++) begin
      data_pad[i] = data_i[i];
    end
    for (int lvl = arb_pkg::IDX_WIDTH - 1; lvl >= 0; lvl--) begin
      for (int l = 0; l < 2 ** lvl; l++) begin
        n = 2 ** lvl - 1 + l;
        if (lvl == arb_pkg::IDX_WIDTH - 1) begin
          data_nodes[n] = sel_v[n] ? data_pad[2*l+1] : data_pad[2*l];
        end else begin
          data_nodes[n] = sel_v[n] ? data_nodes[2*n+2] : data_nodes[2*n+1];
        end
      end
    end
  end

  assign data_o = data_nodes[0];

endmodule

// File: design/tmr_rr_arb_tree.sv
module tmr_rr_arb_tree #(
  parameter bit lock_in = 1'b1
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  input  arb_pkg::req_vec_t                    req_i,
  input  arb_pkg::data_t [arb_pkg::NUM_IN-1:0] data_i,
  output arb_pkg::req_vec_t                    gnt_o,
  output logic                                 req_o,
  input  logic                                 gnt_i,
  output arb_pkg::data_t                       data_o,
  output arb_pkg::idx_t                        idx_o,
  output logic                                 fault_o
);

  // lane outputs, indexed by lane
  arb_pkg::req_vec_t [arb_pkg::NUM_LANES-1:0]  lane_gnt;
  logic [arb_pkg::NUM_LANES-1:0]               lane_req;
  arb_pkg::idx_t [arb_pkg::NUM_LANES-1:0]      lane_idx;
  arb_pkg::node_sel_t [arb_pkg::NUM_LANES-1:0] lane_sel;
  logic [arb_pkg::NUM_LANES-1:0]               lane_fault;
  // registered lane state, exchanged between the lanes
  logic [arb_pkg::NUM_LANES-1:0]               lane_lock;
  arb_pkg::req_vec_t [arb_pkg::NUM_LANES-1:0]  lane_held;
  arb_pkg::idx_t [arb_pkg::NUM_LANES-1:0]      lane_prio;
  // output voters and the data tree
  logic                                        gnt_fault;
  logic                                        req_fault;
  logic                                        idx_fault;
  logic                                        mux_fault;

  ////////////////////////////////////////////////////////////////////////////
  // redundant lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < arb_pkg::NUM_LANES; i++) begin : gen_lane
    logic [1:0]              nbr_lock;
    arb_pkg::req_vec_t [1:0] nbr_req;
    arb_pkg::idx_t [1:0]     nbr_prio;

    // lane i sees lanes i+1 and i+2 in rotation
    for (genvar j = 0; j < 2; j++) begin : gen_nbr
      assign nbr_lock[j] = lane_lock[(i + j + 1) % arb_pkg::NUM_LANES];
      assign nbr_req[j]  = lane_held[(i + j + 1) % arb_pkg::NUM_LANES];
      assign nbr_prio[j] = lane_prio[(i + j + 1) % arb_pkg::NUM_LANES];
    end

    rr_arb_lane #(
      .lock_in (lock_in)
    ) i_lane (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .req_i      (req_i),
      .gnt_i      (gnt_i),
      .nbr_lock_i (nbr_lock),
      .nbr_req_i  (nbr_req),
      .nbr_prio_i (nbr_prio),
      .gnt_o      (lane_gnt[i]),
      .req_o      (lane_req[i]),
      .idx_o      (lane_idx[i]),
      .node_sel_o (lane_sel[i]),
      .lock_o     (lane_lock[i]),
      .held_req_o (lane_held[i]),
      .prio_o     (lane_prio[i]),
      .fault_o    (lane_fault[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // output voting
  ////////////////////////////////////////////////////////////////////////////

  tmr_vote #(.width(arb_pkg::NUM_IN)) i_gnt_vote (
    .a_i     (lane_gnt[0]),
    .b_i     (lane_gnt[1]),
    .c_i     (lane_gnt[2]),
    .maj_o   (gnt_o),
    .fault_o (gnt_fault)
  );

  tmr_vote #(.width(1)) i_req_vote (
    .a_i     (lane_req[0]),
    .b_i     (lane_req[1]),
    .c_i     (lane_req[2]),
    .maj_o   (req_o),
    .fault_o (req_fault)
  );

  tmr_vote #(.width(arb_pkg::IDX_WIDTH)) i_idx_vote (
    .a_i     (lane_idx[0]),
    .b_i     (lane_idx[1]),
    .c_i     (lane_idx[2]),
    .maj_o   (idx_o),
    .fault_o (idx_fault)
  );

  // payload is muxed once, with selects voted across the lanes
  data_tree_mux i_data_mux (
    .node_sel_i (lane_sel),
    .data_i     (data_i),
    .data_o     (data_o),
    .fault_o    (mux_fault)
  );

  // any disagreement anywhere, outputs or lane state, is reported
  assign fault_o = gnt_fault | req_fault | idx_fault | mux_fault | (|lane_fault);

endmodule

// File: sim/tb_tmr_rr_arb_tree.sv
module tb_tmr_rr_arb_tree;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 3;
  localparam int RAND_CYCLES   = 400;
  localparam int FLUSH_TRAFFIC = 30;
  localparam int LOCK_STALL    = 4;
  localparam bit LOCK_IN       = 1'b1;
  // the input that wins the stall in the lock-in test
  localparam int LOCKED        = arb_pkg::NUM_IN - 2;
  // every test with its drain phase, the watchdog allows twice this
  localparam int STIM_CYCLES   = RESET_CYCLES + 6 * arb_pkg::NUM_IN + RAND_CYCLES +
                                 FLUSH_TRAFFIC + LOCK_STALL + 30;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 flush_i;
  arb_pkg::req_vec_t                    req_i;
  arb_pkg::data_t [arb_pkg::NUM_IN-1:0] data_i;
  arb_pkg::req_vec_t                    gnt_o;
  logic                                 req_o;
  logic                                 gnt_i;
  arb_pkg::data_t                       data_o;
  arb_pkg::idx_t                        idx_o;
  logic                                 fault_o;

  // reference state, kept in step with the DUT by the compare process
  arb_pkg::idx_t     m_prio;
  logic              m_lock;
  arb_pkg::req_vec_t m_held;
  // grants seen just before the last edge, so requesters know what to drop
  arb_pkg::req_vec_t seen_gnt;
  logic [31:0]       rng_state;

  tmr_rr_arb_tree #(
    .lock_in (LOCK_IN)
  ) DUT (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .req_i   (req_i),
    .data_i  (data_i),
    .gnt_o   (gnt_o),
    .req_o   (req_o),
    .gnt_i   (gnt_i),
    .data_o  (data_o),
    .idx_o   (idx_o),
    .fault_o (fault_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // walk from the root down, priority bits taken msb first
  function automatic arb_pkg::idx_t arb_model(input arb_pkg::req_vec_t eff,
                                              input arb_pkg::idx_t prio);
    int   base;
    int   size;
    int   half;
    logic lo_any;
    logic hi_any;
    base = 0;
    size = 1 << arb_pkg::IDX_WIDTH;
    for (int lvl = 0; lvl < arb_pkg::IDX_WIDTH; lvl++) begin
      half   = size / 2;
      lo_any = 1'b0;
      hi_any = 1'b0;
      for (int i = 0; i < half; i++) begin
        if (base + i < arb_pkg::NUM_IN) lo_any |= eff[base+i];
        if (base + half + i < arb_pkg::NUM_IN) hi_any |= eff[base+half+i];
      end
      // the upper half wins when the lower one is idle or its priority bit is set
      if (!lo_any || (hi_any && prio[arb_pkg::IDX_WIDTH-1-lvl])) begin
        base += half;
      end
      size = half;
    end
    return arb_pkg::idx_t'(base);
  endfunction

  // lowest requester above the current priority, else the lowest at or below
  function automatic arb_pkg::idx_t next_prio_model(input arb_pkg::req_vec_t eff,
                                                    input arb_pkg::idx_t prio);
    for (int i = int'(prio) + 1; i < arb_pkg::NUM_IN; i++) begin
      if (eff[i]) return arb_pkg::idx_t'(i);
    end
    for (int i = 0; i <= int'(prio); i++) begin
      if (eff[i]) return arb_pkg::idx_t'(i);
    end
    return prio;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare process, runs one ns before every rising edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arb_pkg::req_vec_t eff;
    arb_pkg::req_vec_t exp_gnt;
    arb_pkg::idx_t     exp_idx;
    logic              exp_req;
    forever begin
      @(posedge clk_i);
      #(CLK_PERIOD - 1);
      seen_gnt = gnt_o;
      if (!rst_ni) begin
        m_prio = '0;
        m_lock = 1'b0;
        m_held = '0;
      end else begin
        eff     = m_lock ? m_held : req_i;
        exp_req = |eff;
        exp_idx = arb_model(eff, m_prio);
        exp_gnt = '0;
        if (exp_req && gnt_i) exp_gnt[exp_idx] = 1'b1;
        check_val("req_o", req_o, exp_req);
        if (!gnt_i) check_val("gnt_o while gnt_i low", gnt_o, '0);
        check_val("gnt_o", gnt_o, exp_gnt);
        // idx_o and data_o carry no meaning without a request
        if (exp_req) begin
          check_val("idx_o", idx_o, exp_idx);
          check_val("data_o", data_o, data_i[exp_idx]);
        end
        check_val("fault_o", fault_o, 1'b0);
        if (flush_i) begin
          m_prio = '0;
          m_lock = 1'b0;
          m_held = '0;
        end else begin
          if (exp_req && gnt_i) m_prio = next_prio_model(eff, m_prio);
          m_lock = LOCK_IN && exp_req && !gnt_i;
          m_held = eff;
        end
      end
    end
  end

  initial begin
    #(2 * STIM_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d ns",
             2 * STIM_CYCLES * CLK_PERIOD);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic randomize_data();
    for (int i = 0; i < arb_pkg::NUM_IN; i++) begin
      rng_state = xorshift(rng_state);
      data_i[i] <= arb_pkg::data_t'(rng_state);
    end
  endtask

  // granted requesters drop out, the rest keep waiting with gnt_i high
  // the loop ends with the edge that removes the last pending request
  task automatic drain_requests();
    do begin
      @(posedge clk_i);
      req_i <= req_i & ~seen_gnt;
      gnt_i <= 1'b1;
    end while ((req_i & ~seen_gnt) != '0);
  endtask

  task automatic pulse_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    gnt_i   <= 1'b0;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  task automatic single_requesters();
    for (int i = 0; i < arb_pkg::NUM_IN; i++) begin
      @(posedge clk_i);
      req_i <= arb_pkg::req_vec_t'(1) << i;
      gnt_i <= 1'b1;
      randomize_data();
      @(negedge clk_i);
      check_val("idx_o single", idx_o, i);
      check_val("data_o single", data_o, data_i[i]);
      check_val("gnt_o single", gnt_o, arb_pkg::req_vec_t'(1) << i);
    end
    @(posedge clk_i);
    req_i <= '0;
  endtask

  // starts right after a flush, so the priority begins at input 0
  task automatic fair_rotation();
    for (int k = 0; k < 2 * arb_pkg::NUM_IN; k++) begin
      @(posedge clk_i);
      req_i <= '1;
      gnt_i <= 1'b1;
      randomize_data();
      @(negedge clk_i);
      check_val("idx_o rotation", idx_o, k % arb_pkg::NUM_IN);
      check_val("gnt_o rotation", gnt_o,
                arb_pkg::req_vec_t'(1) << (k % arb_pkg::NUM_IN));
    end
  endtask

  task automatic random_traffic(input int cycles);
    arb_pkg::req_vec_t fresh;
    repeat (cycles) begin
      @(posedge clk_i);
      rng_state = xorshift(rng_state);
      // roughly one request in four per input and cycle
      fresh = arb_pkg::req_vec_t'(rng_state[7:0] & rng_state[15:8]);
      req_i <= (req_i & ~seen_gnt) | fresh;
      gnt_i <= rng_state[16] | rng_state[17];
      randomize_data();
    end
  endtask

  // one request stalls, lower inputs join while locked and must not win
  // the priority is 0 after the preceding flush, so without the lock input 0 would take over
  task automatic lock_in_stall();
    @(posedge clk_i);
    req_i <= arb_pkg::req_vec_t'(1) << LOCKED;
    gnt_i <= 1'b0;
    randomize_data();
    @(negedge clk_i);
    check_val("idx_o at stall", idx_o, LOCKED);
    for (int k = 0; k < LOCK_STALL; k++) begin
      @(posedge clk_i);
      req_i <= (arb_pkg::req_vec_t'(1) << (LOCKED + 1)) - 1;
      @(negedge clk_i);
      check_val("idx_o locked", idx_o, LOCKED);
      check_val("data_o locked", data_o, data_i[LOCKED]);
    end
    @(posedge clk_i);
    gnt_i <= 1'b1;
    @(negedge clk_i);
    check_val("idx_o release", idx_o, LOCKED);
    check_val("gnt_o release", gnt_o, arb_pkg::req_vec_t'(1) << LOCKED);
  endtask

  // with all inputs requesting, input 0 must win after the flush
  task automatic flush_restart();
    @(posedge clk_i);
    req_i   <= '1;
    gnt_i   <= 1'b0;
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    gnt_i   <= 1'b1;
    @(negedge clk_i);
    check_val("idx_o after flush", idx_o, 0);
    check_val("gnt_o after flush", gnt_o, arb_pkg::req_vec_t'(1));
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    flush_i   = 1'b0;
    req_i     = '0;
    gnt_i     = 1'b0;
    data_i    = '0;
    seen_gnt  = '0;
    m_prio    = '0;
    m_lock    = 1'b0;
    m_held    = '0;
    rng_state = 32'h183e;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    single_requesters();
    drain_requests();
    pulse_flush();
    fair_rotation();
    random_traffic(RAND_CYCLES);
    drain_requests();
    pulse_flush();
    lock_in_stall();
    drain_requests();
    random_traffic(FLUSH_TRAFFIC);
    flush_restart();
    drain_requests();
    repeat (2) @(posedge clk_i);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: sources.f
design/arb_pkg.sv
design/tmr_vote.sv
design/trailing_zero_count.sv
design/rr_arb_lane.sv
design/data_tree_mux.sv
design/tmr_rr_arb_tree.sv
sim/tb_tmr_rr_arb_tree.sv

// File: Bender.yml
package:
  name: tmr_rr_arb_tree

sources:
  - design/arb_pkg.sv
  - design/tmr_vote.sv
  - design/trailing_zero_count.sv
  - design/rr_arb_lane.sv
  - design/data_tree_mux.sv
  - design/tmr_rr_arb_tree.sv
  - target: simulation
    files:
      - sim/tb_tmr_rr_arb_tree.sv
